// File: design/ced_pkg.sv
package ced_pkg;

  // image and output memory addressing, sized for up to 128x128
  typedef logic [7:0]  pixel_t;
  typedef logic [13:0] img_addr_t;
  typedef logic [13:0] out_addr_t;

  // gradient components are signed, magnitude is |gx|+|gy|
  typedef logic signed [12:0] grad_t;
  typedef logic [12:0]        mag_t;

  // window tap number, row-major from top-left, 0..8
  typedef logic [3:0] tap_idx_t;

  // direction codes as written to the output memory
  typedef enum logic [12:0] {
    ANG_0   = 13'd0,
    ANG_45  = 13'd45,
    ANG_90  = 13'd90,
    ANG_135 = 13'd135
  } angle_e;

  typedef struct packed {
    logic     valid;
    tap_idx_t idx;
    logic     last;
  } tap_t;

  typedef struct packed {
    grad_t gx;
    grad_t gy;
  } grad_pair_t;

  typedef struct packed {
    mag_t      mag;
    angle_e    ang;
    out_addr_t addr;
  } grad_word_t;

  // (gy << 16) / gx compared against tan 22.5 and tan 67.5 in 16.16
  localparam int RATIO_W = 29;
  localparam logic signed [RATIO_W-1:0] TAN_LO = 'h6A09;
  localparam logic signed [RATIO_W-1:0] TAN_HI = 'h26A09;

endpackage

// File: design/window_decode.sv
`timescale 1ns/1ns

module window_decode
  import ced_pkg::*;
#(
  parameter int IMG_SIZE = 128
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      enable,
  output logic      ird,
  output img_addr_t iaddr,
  output tap_t      tap
);

  localparam int OUT_SIZE = IMG_SIZE - 2;
  localparam int CNT_W    = $clog2(IMG_SIZE);
  localparam img_addr_t ROW_STEP     = img_addr_t'(IMG_SIZE);
  localparam img_addr_t FIRST_CENTRE = img_addr_t'(IMG_SIZE + 1);
  localparam logic [CNT_W-1:0] LAST_POS = CNT_W'(OUT_SIZE - 1);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FINISHED
  } state_e;

  state_e           state;
  tap_idx_t         tap_cnt;
  logic [CNT_W-1:0] col_cnt;
  logic [CNT_W-1:0] row_cnt;
  img_addr_t        centre;
  logic             last_tap;
  logic             last_col;
  logic             last_row;

  assign last_tap = (tap_cnt == 4'd8);
  assign last_col = (col_cnt == LAST_POS);
  assign last_row = (row_cnt == LAST_POS);
  assign ird      = (state == RUN);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (enable) state <= RUN;
        RUN: if (last_tap && last_col && last_row) state <= FINISHED;
        default: state <= FINISHED;
      endcase
    end
  end

  // walk the centre over the interior, skipping the two border columns
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tap_cnt <= '0;
      col_cnt <= '0;
      row_cnt <= '0;
      centre  <= FIRST_CENTRE;
    end else if (ird) begin
      tap_cnt <= last_tap ? '0 : tap_cnt + 4'd1;
      if (last_tap) begin
        if (last_col) begin
          col_cnt <= '0;
          row_cnt <= row_cnt + 1'b1;
          centre  <= centre + img_addr_t'(3);
        end else begin
          col_cnt <= col_cnt + 1'b1;
          centre  <= centre + img_addr_t'(1);
        end
      end
    end
  end

  // tap offset around the centre
  always_comb begin
    case (tap_cnt)
      4'd0: iaddr = centre - ROW_STEP - img_addr_t'(1);
      4'd1: iaddr = centre - ROW_STEP;
      4'd2: iaddr = centre - ROW_STEP + img_addr_t'(1);
      4'd3: iaddr = centre - img_addr_t'(1);
      4'd5: iaddr = centre + img_addr_t'(1);
      4'd6: iaddr = centre + ROW_STEP - img_addr_t'(1);
      4'd7: iaddr = centre + ROW_STEP;
      4'd8: iaddr = centre + ROW_STEP + img_addr_t'(1);
      default: iaddr = centre;
    endcase
  end

  // delayed one cycle to line up with idata
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tap <= '0;
    end else begin
      tap.valid <= ird;
      tap.idx   <= tap_cnt;
      tap.last  <= ird && last_tap;
    end
  end

  a_iaddr_in_image: assert property (@(posedge clk) disable iff (rst)
    ird |-> (int'(iaddr) < IMG_SIZE * IMG_SIZE))
    else $error("window_decode: iaddr %0d outside the image", iaddr);

endmodule

// File: design/sobel_execute.sv
`timescale 1ns/1ns

module sobel_execute
  import ced_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  pixel_t     idata,
  input  tap_t       tap,
  output grad_pair_t grad,
  output logic       grad_valid
);

  grad_t px;
  grad_t px2;
  grad_t wx;
  grad_t wy;
  grad_t sum_x;
  grad_t sum_y;
  grad_t base_x;
  grad_t base_y;
  grad_t next_x;
  grad_t next_y;

  // sample as a positive signed value, and doubled
  assign px  = {5'b0, idata};
  assign px2 = px <<< 1;

  // gx: -1 0 1 / -2 0 2 / -1 0 1
  // gy: -1 -2 -1 / 0 0 0 / 1 2 1
  always_comb begin
    wx = '0;
    wy = '0;
    case (tap.idx)
      4'd0: begin
        wx = -px;
        wy = -px;
      end
      4'd1: wy = -px2;
      4'd2: begin
        wx = px;
        wy = -px;
      end
      4'd3: wx = -px2;
      4'd5: wx = px2;
      4'd6: begin
        wx = -px;
        wy = px;
      end
      4'd7: wy = px2;
      4'd8: begin
        wx = px;
        wy = px;
      end
      default: begin
        wx = '0;
        wy = '0;
      end
    endcase
  end

  // sums start over on tap 0
  assign base_x = (tap.idx == 4'd0) ? '0 : sum_x;
  assign base_y = (tap.idx == 4'd0) ? '0 : sum_y;
  assign next_x = base_x + wx;
  assign next_y = base_y + wy;

  always_ff @(posedge clk) begin
    if (tap.valid) begin
      sum_x <= next_x;
      sum_y <= next_y;
    end
    if (tap.valid && tap.last) begin
      grad.gx <= next_x;
      grad.gy <= next_y;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      grad_valid <= 1'b0;
    end else begin
      grad_valid <= tap.valid && tap.last;
    end
  end

  // a window arrives as nine taps back to back
  a_taps_in_order: assert property (@(posedge clk) disable iff (rst)
    tap.valid && !tap.last |=> tap.valid && (tap.idx == $past(tap.idx) + 4'd1))
    else $error("sobel_execute: tap sequence broken after tap %0d", $past(tap.idx));

endmodule

// File: design/gradient_result.sv
`timescale 1ns/1ns

module gradient_result
  import ced_pkg::*;
#(
  parameter int IMG_SIZE = 128
) (
  input  logic       clk,
  input  logic       rst,
  input  grad_pair_t grad,
  input  logic       grad_valid,
  output logic       grad_wr,
  output grad_word_t grad_out,
  output logic       done
);

  localparam int OUT_SIZE = IMG_SIZE - 2;
  localparam out_addr_t LAST_ADDR = out_addr_t'(OUT_SIZE * OUT_SIZE - 1);

  grad_t                     gx;
  grad_t                     gy;
  mag_t                      abs_gx;
  mag_t                      abs_gy;
  mag_t                      mag;
  logic signed [RATIO_W-1:0] dividend;
  logic signed [RATIO_W-1:0] divisor;
  logic signed [RATIO_W-1:0] ratio;
  angle_e                    ang;
  out_addr_t                 wr_addr;

  assign gx = grad.gx;
  assign gy = grad.gy;

  // magnitude |gx|+|gy|
  assign abs_gx = gx[12] ? mag_t'(-gx) : mag_t'(gx);
  assign abs_gy = gy[12] ? mag_t'(-gy) : mag_t'(gy);
  assign mag    = abs_gx + abs_gy;

  // slope gy/gx in 16.16, truncated toward zero
  // divisor forced to 1 when gx is zero
  // the sector rule settles gx zero before the ratio is used
  assign dividend = {gy, 16'b0};
  assign divisor  = (gx == '0) ? 1 : gx;
  assign ratio    = dividend / divisor;

  // sector classification
  always_comb begin
    if (gx == '0 && gy == '0) begin
      ang = ANG_0;
    end else if (gx == '0) begin
      ang = ANG_90;
    end else if (ratio > -TAN_LO && ratio < TAN_LO) begin
      ang = ANG_0;
    end else if (ratio >= TAN_LO && ratio <= TAN_HI) begin
      ang = ANG_45;
    end else if (ratio >= -TAN_HI && ratio <= -TAN_LO) begin
      ang = ANG_135;
    end else begin
      ang = ANG_90;
    end
  end

  // write strobe, address counter, done flag
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      grad_wr <= 1'b0;
      wr_addr <= '0;
      done    <= 1'b0;
    end else begin
      grad_wr <= grad_valid;
      if (grad_valid) begin
        wr_addr <= wr_addr + out_addr_t'(1);
      end
      if (grad_wr && grad_out.addr == LAST_ADDR) begin
        done <= 1'b1;
      end
    end
  end

  // output word, held between writes
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      grad_out.mag  <= '0;
      grad_out.ang  <= ANG_0;
      grad_out.addr <= '0;
    end else if (grad_valid) begin
      grad_out.mag  <= mag;
      grad_out.ang  <= ang;
      grad_out.addr <= wr_addr;
    end
  end

  a_no_write_after_done: assert property (@(posedge clk) disable iff (rst)
    done |-> !grad_wr)
    else $error("gradient_result: write at address %0d after done", grad_out.addr);

  a_ang_code: assert property (@(posedge clk) disable iff (rst)
    grad_out.ang inside {ANG_0, ANG_45, ANG_90, ANG_135})
    else $error("gradient_result: illegal angle code %0d", grad_out.ang);

endmodule

// File: design/ced_top.sv
`timescale 1ns/1ns

module ced_top
  import ced_pkg::*;
#(
  parameter int IMG_SIZE = 128
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       enable,
  output logic       ird,
  output img_addr_t  iaddr,
  input  pixel_t     idata,
  output logic       grad_wr,
  output grad_word_t grad_out,
  output logic       done
);

  // tap info travels with the returning sample
  tap_t       tap;
  grad_pair_t grad;
  logic       grad_valid;

  // window address walker on the image read port
  window_decode #(
    .IMG_SIZE (IMG_SIZE)
  ) u_window_decode (
    .clk    (clk),
    .rst    (rst),
    .enable (enable),
    .ird    (ird),
    .iaddr  (iaddr),
    .tap    (tap)
  );

  // gx/gy accumulation over the nine taps
  sobel_execute u_sobel_execute (
    .clk        (clk),
    .rst        (rst),
    .idata      (idata),
    .tap        (tap),
    .grad       (grad),
    .grad_valid (grad_valid)
  );

  // magnitude, direction and output write
  gradient_result #(
    .IMG_SIZE (IMG_SIZE)
  ) u_gradient_result (
    .clk        (clk),
    .rst        (rst),
    .grad       (grad),
    .grad_valid (grad_valid),
    .grad_wr    (grad_wr),
    .grad_out   (grad_out),
    .done       (done)
  );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD = 4
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

// File: testbench/ced_tb.sv
`timescale 1ns/1ns

module ced_tb
  import ced_pkg::*;
;

  localparam int IMG_SIZE  = 16;
  localparam int OUT_SIZE  = IMG_SIZE - 2;
  localparam int NPIX      = OUT_SIZE * OUT_SIZE;
  localparam int TAP_TOTAL = 9 * NPIX;
  localparam int WATCHDOG_CYCLES = 9 * NPIX + 200;
  // tan 22.5 and tan 67.5 in 16.16
  localparam int TAN_LO_REF = 'h6A09;
  localparam int TAN_HI_REF = 'h26A09;

  logic       clk;
  logic       rst;
  logic       enable;
  logic       ird;
  img_addr_t  iaddr;
  pixel_t     idata;
  logic       grad_wr;
  grad_word_t grad_out;
  logic       done;

  pixel_t     img [IMG_SIZE * IMG_SIZE];
  integer     seed;
  bit         enable_sent;
  int         rd_count;
  int         wr_count;
  grad_word_t exp_word;

  tb_clock #(.PERIOD(4)) u_clock (.clk(clk));

  ced_top #(
    .IMG_SIZE (IMG_SIZE)
  ) uut (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .ird      (ird),
    .iaddr    (iaddr),
    .idata    (idata),
    .grad_wr  (grad_wr),
    .grad_out (grad_out),
    .done     (done)
  );

  // image memory, one cycle read latency
  always @(posedge clk) begin
    if (ird) begin
      idata <= img[iaddr];
    end
  end

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_mag(input string name, input mag_t exp, input mag_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_ang(input string name, input angle_e exp, input angle_e act);
    if (act !== exp) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input out_addr_t exp, input out_addr_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_iaddr(input string name, input img_addr_t exp, input img_addr_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  // centre of output pixel plus the tap offset, taps row-major
  function automatic int window_addr(input int pix, input int tap);
    int r;
    int c;
    r = pix / OUT_SIZE + 1;
    c = pix % OUT_SIZE + 1;
    return (r + tap / 3 - 1) * IMG_SIZE + c + tap % 3 - 1;
  endfunction

  // expected output word for output index k
  function automatic grad_word_t ref_word(input int k);
    int dx;
    int dy;
    int p;
    int gx;
    int gy;
    int ratio;
    grad_word_t w;
    gx = 0;
    gy = 0;
    for (int t = 0; t < 9; t++) begin
      dx = t % 3 - 1;
      dy = t / 3 - 1;
      p  = img[window_addr(k, t)];
      // centre row and column carry weight 2
      gx += dx * ((dy == 0) ? 2 : 1) * p;
      gy += dy * ((dx == 0) ? 2 : 1) * p;
    end
    w.mag  = mag_t'(((gx < 0) ? -gx : gx) + ((gy < 0) ? -gy : gy));
    w.addr = out_addr_t'(k);
    if (gx == 0 && gy == 0) begin
      w.ang = ANG_0;
    end else if (gx == 0) begin
      w.ang = ANG_90;
    end else begin
      ratio = (gy * 65536) / gx;
      if (ratio > -TAN_LO_REF && ratio < TAN_LO_REF) begin
        w.ang = ANG_0;
      end else if (ratio >= TAN_LO_REF && ratio <= TAN_HI_REF) begin
        w.ang = ANG_45;
      end else if (ratio >= -TAN_HI_REF && ratio <= -TAN_LO_REF) begin
        w.ang = ANG_135;
      end else begin
        w.ang = ANG_90;
      end
    end
    return w;
  endfunction

  // random image, rows 1..4 hold five 3-column patches
  task automatic fill_image();
    for (int a = 0; a < IMG_SIZE * IMG_SIZE; a++) begin
      img[a] = pixel_t'($random(seed));
    end
    for (int r = 1; r <= 4; r++) begin
      for (int c = 0; c < 15; c++) begin
        case (c / 3)
          0: img[r * IMG_SIZE + c] = pixel_t'(c * 8);
          1: img[r * IMG_SIZE + c] = pixel_t'(r * 20);
          2: img[r * IMG_SIZE + c] = pixel_t'((r + c) * 10);
          3: img[r * IMG_SIZE + c] = pixel_t'(100 + c * 10 - r * 10);
          default: img[r * IMG_SIZE + c] = pixel_t'(77);
        endcase
      end
    end
  endtask

  // outputs quiet until the run is started
  always @(negedge clk) begin
    if (!enable_sent) begin
      check_level("ird before enable", 1'b0, ird);
      check_level("grad_wr before enable", 1'b0, grad_wr);
      check_level("done before enable", 1'b0, done);
    end
  end

  // read address walk, written words, quiet after done
  always @(negedge clk) begin
    if (!rst) begin
      if (ird) begin
        if (rd_count >= TAP_TOTAL) begin
          $display("image port read more than %0d times", TAP_TOTAL);
          stop_run();
        end
        check_iaddr($sformatf("image address pixel %0d tap %0d", rd_count / 9, rd_count % 9),
                    img_addr_t'(window_addr(rd_count / 9, rd_count % 9)), iaddr);
        rd_count++;
      end
      if (grad_wr) begin
        if (wr_count >= NPIX) begin
          $display("more than %0d output writes", NPIX);
          stop_run();
        end
        exp_word = ref_word(wr_count);
        check_mag($sformatf("magnitude pixel %0d", wr_count), exp_word.mag, grad_out.mag);
        check_ang($sformatf("angle pixel %0d", wr_count), exp_word.ang, grad_out.ang);
        check_addr($sformatf("write address %0d", wr_count), exp_word.addr, grad_out.addr);
        wr_count++;
      end
      if (done) begin
        check_level("ird after done", 1'b0, ird);
        check_level("grad_wr after done", 1'b0, grad_wr);
      end
    end
  end

  initial begin
    seed        = 5;
    rst         = 1'b1;
    enable      = 1'b0;
    idata       = '0;
    enable_sent = 1'b0;
    rd_count    = 0;
    wr_count    = 0;
    fill_image();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);
    enable <= 1'b1;
    enable_sent = 1'b1;
    @(posedge clk);
    enable <= 1'b0;
    while (done !== 1'b1) begin
      @(negedge clk);
    end
    check_count("writes before done", NPIX, wr_count);
    check_count("image reads before done", TAP_TOTAL, rd_count);
    repeat (20) begin
      @(negedge clk);
      check_level("done held high", 1'b1, done);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // run length bound from the pixel count
  initial begin
    wait (rst === 1'b0);
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: done not seen within %0d cycles after reset", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: all.f
design/ced_pkg.sv
design/window_decode.sv
design/sobel_execute.sv
design/gradient_result.sv
design/ced_top.sv
testbench/tb_clock.sv
testbench/ced_tb.sv

// File: Bender.yml
package:
  name: ced_sobel

sources:
  - design/ced_pkg.sv
  - design/window_decode.sv
  - design/sobel_execute.sv
  - design/gradient_result.sv
  - design/ced_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/ced_tb.sv
